// ==== src/udp_tx_defines.svh ====
`ifndef UDP_TX_DEFINES_SVH
`define UDP_TX_DEFINES_SVH

// Payload FIFO depth as log2, 2048 bytes
`define UDP_TX_PKT_ADDR_W 11

// Control FIFO depth as log2, 16 frame records
`define UDP_TX_CTRL_ADDR_W 4

// Free entries left when almost-full rises
`define UDP_TX_AFULL_MARGIN 8

// Register the application inputs for one cycle
`define UDP_TX_REG_APP_IF 1

// Header sizes in bytes
`define UDP_TX_MAC_HDR 14
`define UDP_TX_IP_HDR 20
`define UDP_TX_UDP_HDR 8

`endif

// ==== src/udp_tx_pkg.sv ====
package udp_tx_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;

  // Payload byte count, also the type of the IP and UDP length fields
  typedef logic [15:0] frame_len_t;

  // IP header checksum word
  typedef logic [15:0] csum_t;

  // Byte position within one header section
  typedef logic [5:0]  hdr_idx_t;

  // One record per frame in the control FIFO
  typedef struct packed {
    frame_len_t size;
    udp_port_t  dest_port;
    ip_addr_t   dest_ip;
  } udp_tx_ctrl_t;

  // Local station settings
  typedef struct packed {
    mac_addr_t mac;
    ip_addr_t  ip;
    udp_port_t port;
    byte_t     gateway;  // ARP table index of the default gateway
  } udp_tx_local_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_MAC_HDR,
    TX_IP_HDR,
    TX_UDP_HDR,
    TX_PAYLOAD
  } tx_state_t;

endpackage

// ==== src/udp_tx_fifo.sv ====
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_tx_fifo #(
  parameter int WIDTH  = 8,
  parameter int ADDR_W = 4
) (
  input  logic             mac_clk,
  input  logic             app_rst,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             afull,
  output logic             overflow
);

  localparam int DEPTH = 2 ** ADDR_W;
  localparam logic [ADDR_W:0] FULL_LEVEL  = (ADDR_W + 1)'(DEPTH);
  localparam logic [ADDR_W:0] AFULL_LEVEL = (ADDR_W + 1)'(DEPTH - `UDP_TX_AFULL_MARGIN);

  logic [WIDTH-1:0]  mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   count;
  logic              full;
  logic              wr_ok;
  logic              rd_ok;

  assign full  = (count == FULL_LEVEL);
  assign empty = (count == '0);
  assign afull = (count >= AFULL_LEVEL);

  // Writes into a full buffer are dropped
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  // First word falls through, the head entry is always on dout
  assign dout = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // One cycle pulse per dropped write
      overflow <= wr_en && full;
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/udp_tx_app_if.sv ====
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_tx_app_if (
  input  logic                     mac_clk,
  input  logic                     app_rst,
  input  udp_tx_pkg::byte_t        app_data,
  input  logic                     app_dvld,
  input  logic                     app_eof,
  input  udp_tx_pkg::ip_addr_t     app_destip,
  input  udp_tx_pkg::udp_port_t    app_destport,
  output udp_tx_pkg::byte_t        pkt_din,
  output logic                     pkt_wr,
  output udp_tx_pkg::udp_tx_ctrl_t ctrl_din,
  output logic                     ctrl_wr,
  input  logic                     pkt_afull,
  input  logic                     ctrl_afull,
  input  logic                     pkt_overflow,
  input  logic                     ctrl_overflow,
  output logic                     app_afull,
  output logic                     app_overflow
);
  import udp_tx_pkg::*;

  byte_t      data_int;
  logic       dvld_int;
  logic       last_int;
  ip_addr_t   destip_int;
  udp_port_t  destport_int;
  frame_len_t byte_cnt;

  generate
    if (`UDP_TX_REG_APP_IF != 0) begin : gen_in_reg
      byte_t     data_q;
      ip_addr_t  destip_q;
      udp_port_t destport_q;
      logic      dvld_q;
      logic      last_q;

      always_ff @(posedge mac_clk) begin
        data_q     <= app_data;
        destip_q   <= app_destip;
        destport_q <= app_destport;
      end

      always_ff @(posedge mac_clk) begin
        if (app_rst) begin
          dvld_q <= 1'b0;
          last_q <= 1'b0;
        end else begin
          dvld_q <= app_dvld;
          last_q <= app_dvld && app_eof;
        end
      end

      assign data_int     = data_q;
      assign dvld_int     = dvld_q;
      assign last_int     = last_q;
      assign destip_int   = destip_q;
      assign destport_int = destport_q;
    end else begin : gen_in_comb
      assign data_int     = app_data;
      assign dvld_int     = app_dvld;
      assign last_int     = app_dvld && app_eof;
      assign destip_int   = app_destip;
      assign destport_int = app_destport;
    end
  endgenerate

  assign pkt_din  = data_int;
  assign pkt_wr   = dvld_int;
  assign ctrl_wr  = last_int;
  assign ctrl_din = '{size: byte_cnt, dest_port: destport_int, dest_ip: destip_int};

  // Starts at 1 so the count already includes the last byte when it is written
  always_ff @(posedge mac_clk) begin
    if (app_rst || ctrl_wr) begin
      byte_cnt <= 16'd1;
    end else if (pkt_wr) begin
      byte_cnt <= byte_cnt + 16'd1;
    end
  end

  assign app_afull = pkt_afull || ctrl_afull;

  // Sticky until reset
  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      app_overflow <= 1'b0;
    end else if (pkt_overflow || ctrl_overflow) begin
      app_overflow <= 1'b1;
    end
  end

endmodule

// ==== src/udp_tx_hdr_calc.sv ====
`timescale 1ns/1ps

module udp_tx_hdr_calc (
  input  logic                      mac_clk,
  input  udp_tx_pkg::udp_tx_ctrl_t  ctrl,
  input  udp_tx_pkg::udp_tx_local_t local_cfg,
  output udp_tx_pkg::frame_len_t    ip_length,
  output udp_tx_pkg::frame_len_t    udp_length,
  output udp_tx_pkg::csum_t         ip_checksum,
  output udp_tx_pkg::byte_t         arp_addr
);
  import udp_tx_pkg::*;

  // Constant IP header words: version/IHL/TOS, flags, TTL/protocol
  localparam csum_t VER_TOS   = 16'h4500;
  localparam csum_t FLAGS     = 16'h4000;
  localparam csum_t TTL_PROTO = 16'hFF11;

  // Header bytes on top of the payload
  localparam frame_len_t IP_OVERHEAD  = 16'd28;
  localparam frame_len_t UDP_OVERHEAD = 16'd8;

  frame_len_t  ip_len_c;
  logic [18:0] sum_c;
  logic [18:0] sum_s1;
  logic [16:0] sum_s2;
  frame_len_t  ip_len_s1;
  frame_len_t  ip_len_s2;
  frame_len_t  udp_len_s1;
  frame_len_t  udp_len_s2;

  assign ip_len_c = ctrl.size + IP_OVERHEAD;

  // Eight 16 bit words, the sum fits in 19 bits
  assign sum_c = 19'(VER_TOS) + 19'(FLAGS) + 19'(TTL_PROTO) + 19'(ip_len_c)
               + 19'(local_cfg.ip[31:16]) + 19'(local_cfg.ip[15:0])
               + 19'(ctrl.dest_ip[31:16]) + 19'(ctrl.dest_ip[15:0]);

  always_ff @(posedge mac_clk) begin
    // Stage 1 raw sum and lengths
    sum_s1     <= sum_c;
    ip_len_s1  <= ip_len_c;
    udp_len_s1 <= ctrl.size + UDP_OVERHEAD;

    // Stage 2 first carry fold
    sum_s2     <= 17'(sum_s1[15:0]) + 17'(sum_s1[18:16]);
    ip_len_s2  <= ip_len_s1;
    udp_len_s2 <= udp_len_s1;

    // Stage 3 second fold cannot carry again
    ip_checksum <= ~(sum_s2[15:0] + 16'(sum_s2[16]));
    ip_length   <= ip_len_s2;
    udp_length  <= udp_len_s2;
  end

  // Same /24 subnet goes direct, anything else via the gateway
  assign arp_addr = (ctrl.dest_ip[31:8] == local_cfg.ip[31:8]) ? ctrl.dest_ip[7:0]
                                                               : local_cfg.gateway;

endmodule

// ==== src/udp_tx_framer.sv ====
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_tx_framer (
  input  logic                      mac_clk,
  input  logic                      app_rst,
  input  udp_tx_pkg::udp_tx_ctrl_t  ctrl,
  input  logic                      ctrl_empty,
  output logic                      ctrl_rd,
  input  udp_tx_pkg::byte_t         pkt_dout,
  output logic                      pkt_rd,
  input  udp_tx_pkg::frame_len_t    ip_length,
  input  udp_tx_pkg::frame_len_t    udp_length,
  input  udp_tx_pkg::csum_t         ip_checksum,
  input  udp_tx_pkg::mac_addr_t     dest_mac,
  input  udp_tx_pkg::udp_tx_local_t local_cfg,
  input  logic                      local_enable,
  input  logic                      app_overflow,
  output udp_tx_pkg::byte_t         mac_tx_data,
  output logic                      mac_tx_dvld,
  output logic                      sop,
  output logic                      eop,
  input  logic                      mac_tx_ack
);
  import udp_tx_pkg::*;

  localparam hdr_idx_t MAC_LAST = hdr_idx_t'(`UDP_TX_MAC_HDR - 1);
  localparam hdr_idx_t IP_LAST  = hdr_idx_t'(`UDP_TX_IP_HDR - 1);
  localparam hdr_idx_t UDP_LAST = hdr_idx_t'(`UDP_TX_UDP_HDR - 1);

  tx_state_t  state;
  hdr_idx_t   progress;
  frame_len_t tx_count;
  logic       last_byte;

  logic [`UDP_TX_MAC_HDR*8-1:0] mac_vec;
  logic [`UDP_TX_IP_HDR*8-1:0]  ip_vec;
  logic [`UDP_TX_UDP_HDR*8-1:0] udp_vec;

  // Header sections, first transmitted byte in the top bits
  assign mac_vec = {dest_mac, local_cfg.mac, 16'h0800};
  assign ip_vec  = {8'h45, 8'h00, ip_length, 16'h0000, 16'h4000, 8'hFF, 8'h11,
                    ip_checksum, local_cfg.ip, ctrl.dest_ip};
  assign udp_vec = {local_cfg.port, ctrl.dest_port, udp_length, 16'h0000};

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      state    <= TX_IDLE;
      progress <= '0;
      tx_count <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          progress <= '0;
          if (!ctrl_empty && !app_overflow && local_enable) begin
            state    <= TX_MAC_HDR;
            tx_count <= ctrl.size;
          end
        end
        TX_MAC_HDR: begin
          if (mac_tx_ack) begin
            progress <= (progress == MAC_LAST) ? '0 : progress + 1'b1;
            if (progress == MAC_LAST) begin
              state <= TX_IP_HDR;
            end
          end
        end
        TX_IP_HDR: begin
          if (mac_tx_ack) begin
            progress <= (progress == IP_LAST) ? '0 : progress + 1'b1;
            if (progress == IP_LAST) begin
              state <= TX_UDP_HDR;
            end
          end
        end
        TX_UDP_HDR: begin
          if (mac_tx_ack) begin
            progress <= (progress == UDP_LAST) ? '0 : progress + 1'b1;
            if (progress == UDP_LAST) begin
              state <= TX_PAYLOAD;
            end
          end
        end
        TX_PAYLOAD: begin
          if (mac_tx_ack) begin
            tx_count <= tx_count - 16'd1;
            // Frame ends with the acknowledge of the eop byte
            if (last_byte) begin
              state <= TX_IDLE;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Byte mux, held steady until the MAC acknowledges
  always_comb begin
    case (state)
      TX_MAC_HDR: mac_tx_data = mac_vec[(MAC_LAST - progress) * 8 +: 8];
      TX_IP_HDR:  mac_tx_data = ip_vec[(IP_LAST - progress) * 8 +: 8];
      TX_UDP_HDR: mac_tx_data = udp_vec[(UDP_LAST - progress) * 8 +: 8];
      TX_PAYLOAD: mac_tx_data = pkt_dout;
      default:    mac_tx_data = 8'h00;
    endcase
  end

  assign last_byte   = (state == TX_PAYLOAD) && (tx_count == 16'd1);
  assign mac_tx_dvld = (state != TX_IDLE);
  assign sop         = (state == TX_MAC_HDR) && (progress == '0);
  assign eop         = last_byte;

  // Control record leaves the FIFO together with its last payload byte
  assign pkt_rd  = (state == TX_PAYLOAD) && mac_tx_ack;
  assign ctrl_rd = last_byte && mac_tx_ack;

endmodule

// ==== src/udp_tx_top.sv ====
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_tx_top (
  input  logic                      mac_clk,
  input  logic                      app_rst,
  input  udp_tx_pkg::byte_t         app_data,
  input  logic                      app_dvld,
  input  logic                      app_eof,
  input  udp_tx_pkg::ip_addr_t      app_destip,
  input  udp_tx_pkg::udp_port_t     app_destport,
  output logic                      app_afull,
  output logic                      app_overflow,
  input  logic                      local_enable,
  input  udp_tx_pkg::udp_tx_local_t local_cfg,
  output udp_tx_pkg::byte_t         arp_cache_addr,
  input  udp_tx_pkg::mac_addr_t     arp_cache_rd_data,
  output udp_tx_pkg::byte_t         mac_tx_data,
  output logic                      mac_tx_dvld,
  input  logic                      mac_tx_ack,
  output logic                      sop,
  output logic                      eop
);
  import udp_tx_pkg::*;

  byte_t        pkt_din;
  logic         pkt_wr;
  byte_t        pkt_dout;
  logic         pkt_rd;
  logic         pkt_afull;
  logic         pkt_overflow;
  udp_tx_ctrl_t ctrl_din;
  logic         ctrl_wr;
  udp_tx_ctrl_t ctrl_dout;
  logic         ctrl_rd;
  logic         ctrl_empty;
  logic         ctrl_afull;
  logic         ctrl_overflow;
  frame_len_t   ip_length;
  frame_len_t   udp_length;
  csum_t        ip_checksum;

  udp_tx_app_if app_if (
    .mac_clk, .app_rst, .app_data, .app_dvld, .app_eof, .app_destip, .app_destport,
    .pkt_din, .pkt_wr, .ctrl_din, .ctrl_wr,
    .pkt_afull, .ctrl_afull, .pkt_overflow, .ctrl_overflow,
    .app_afull, .app_overflow
  );

  // Payload bytes; the control record count tells the framer where a frame ends
  udp_tx_fifo #(.WIDTH($bits(byte_t)), .ADDR_W(`UDP_TX_PKT_ADDR_W)) pkt_fifo (
    .mac_clk, .app_rst, .din(pkt_din), .wr_en(pkt_wr), .rd_en(pkt_rd),
    .dout(pkt_dout), .empty(), .afull(pkt_afull), .overflow(pkt_overflow)
  );

  udp_tx_fifo #(.WIDTH($bits(udp_tx_ctrl_t)), .ADDR_W(`UDP_TX_CTRL_ADDR_W)) ctrl_fifo (
    .mac_clk, .app_rst, .din(ctrl_din), .wr_en(ctrl_wr), .rd_en(ctrl_rd),
    .dout(ctrl_dout), .empty(ctrl_empty), .afull(ctrl_afull), .overflow(ctrl_overflow)
  );

  udp_tx_hdr_calc hdr_calc (
    .mac_clk, .ctrl(ctrl_dout), .local_cfg,
    .ip_length, .udp_length, .ip_checksum, .arp_addr(arp_cache_addr)
  );

  udp_tx_framer framer (
    .mac_clk, .app_rst, .ctrl(ctrl_dout), .ctrl_empty, .ctrl_rd, .pkt_dout, .pkt_rd,
    .ip_length, .udp_length, .ip_checksum, .dest_mac(arp_cache_rd_data),
    .local_cfg, .local_enable, .app_overflow,
    .mac_tx_data, .mac_tx_dvld, .sop, .eop, .mac_tx_ack
  );

endmodule

// ==== verification/udp_tx_checker.sv ====
`timescale 1ns/1ps

module udp_tx_checker (
  input logic              mac_clk,
  input logic              app_rst,
  input udp_tx_pkg::byte_t mac_tx_data,
  input logic              mac_tx_dvld,
  input logic              mac_tx_ack,
  input logic              sop,
  input logic              eop,
  input logic              app_overflow
);

  int err_count = 0;

  // Framer is idle in the first cycle out of reset
  idle_after_reset: assert property (@(posedge mac_clk) app_rst |=> !mac_tx_dvld)
    else begin
      err_count++;
      $error("mac_tx_dvld high in the cycle after reset");
    end

  flags_in_frame: assert property (@(posedge mac_clk) disable iff (app_rst)
    (sop || eop) |-> mac_tx_dvld)
    else begin
      err_count++;
      $error("sop or eop outside a frame");
    end

  // MAC back-pressure holds the byte
  data_held: assert property (@(posedge mac_clk) disable iff (app_rst)
    (mac_tx_dvld && !mac_tx_ack) |=> $stable(mac_tx_data))
    else begin
      err_count++;
      $error("mac_tx_data changed without an acknowledge");
    end

  overflow_sticky: assert property (@(posedge mac_clk)
    (app_overflow && !app_rst) |=> app_overflow)
    else begin
      err_count++;
      $error("app_overflow cleared without reset");
    end

endmodule

bind udp_tx_top udp_tx_checker chk (.*);

// ==== verification/udp_tx_tb.sv ====
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_tx_tb;
  import udp_tx_pkg::*;

  localparam int HDR_BYTES = `UDP_TX_MAC_HDR + `UDP_TX_IP_HDR + `UDP_TX_UDP_HDR;

  // One transmitted byte with its frame flags
  typedef struct packed {
    logic  sop;
    logic  eop;
    byte_t data;
  } tx_beat_t;

  logic          mac_clk;
  logic          app_rst;
  byte_t         app_data;
  logic          app_dvld;
  logic          app_eof;
  ip_addr_t      app_destip;
  udp_port_t     app_destport;
  logic          app_afull;
  logic          app_overflow;
  logic          local_enable;
  udp_tx_local_t local_cfg;
  byte_t         arp_cache_addr;
  mac_addr_t     arp_cache_rd_data;
  byte_t         mac_tx_data;
  logic          mac_tx_dvld;
  logic          mac_tx_ack;
  logic          sop;
  logic          eop;

  integer     seed;
  logic       ack_random;
  int         frame_num;
  int         afull_at;
  int         ovf_at;
  frame_len_t rand_len [5];
  ip_addr_t   rand_ip [5];
  tx_beat_t   exp_q [$];
  tx_beat_t   cap_q [$];

  udp_tx_top UUT (.*);

  always #10 mac_clk = ~mac_clk;

  // ARP table returns 02:00:00:00:00 and the index
  assign arp_cache_rd_data = {40'h02_0000_0000, arp_cache_addr};

  always @(posedge mac_clk) begin
    mac_tx_ack <= ack_random ? (($random(seed) & 3) != 0) : 1'b1;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [7:0] got, logic [7:0] want);
    assert (got === want) else begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, want);
      abort_run();
    end
  endtask

  function automatic byte_t payload_byte(int frame_id, int idx);
    return byte_t'(frame_id * 29 + idx * 13 + 'h5A);
  endfunction

  // Expected bytes of one frame from the header layout and the payload pattern
  function automatic void build_frame(frame_len_t size, ip_addr_t dip, udp_port_t dport,
                                      int frame_id);
    logic [HDR_BYTES*8-1:0] hdr;
    logic [31:0]            sum;
    frame_len_t             ip_len;
    frame_len_t             udp_len;
    byte_t                  arp_idx;
    ip_len  = size + 16'd28;
    udp_len = size + 16'd8;
    arp_idx = (dip[31:8] == local_cfg.ip[31:8]) ? dip[7:0] : local_cfg.gateway;
    sum = 32'h4500 + ip_len + 32'h4000 + 32'hFF11 + local_cfg.ip[31:16]
        + local_cfg.ip[15:0] + dip[31:16] + dip[15:0];
    sum = sum[15:0] + sum[31:16];
    sum = sum[15:0] + sum[31:16];
    hdr = {40'h02_0000_0000, arp_idx, local_cfg.mac, 16'h0800,
           8'h45, 8'h00, ip_len, 16'h0000, 16'h4000, 8'hFF, 8'h11, ~sum[15:0],
           local_cfg.ip, dip, local_cfg.port, dport, udp_len, 16'h0000};
    for (int i = 0; i < HDR_BYTES; i++) begin
      exp_q.push_back('{sop: (i == 0), eop: 1'b0, data: hdr[(HDR_BYTES-1-i)*8 +: 8]});
    end
    for (int j = 0; j < size; j++) begin
      exp_q.push_back('{sop: 1'b0, eop: (j == size - 1), data: payload_byte(frame_id, j)});
    end
  endfunction

  task automatic hold_reset();
    app_rst <= 1'b1;
    repeat (5) @(posedge mac_clk);
    app_rst <= 1'b0;
  endtask

  task automatic send_frame(frame_len_t size, ip_addr_t dip, udp_port_t dport);
    build_frame(size, dip, dport, frame_num);
    for (int i = 0; i < size; i++) begin
      @(posedge mac_clk);
      app_data     <= payload_byte(frame_num, i);
      app_dvld     <= 1'b1;
      app_eof      <= (i == size - 1);
      app_destip   <= dip;
      app_destport <= dport;
    end
    @(posedge mac_clk);
    app_dvld <= 1'b0;
    app_eof  <= 1'b0;
    frame_num++;
  endtask

  task automatic wait_drained(int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 || mac_tx_dvld) begin
      @(posedge mac_clk);
      n++;
      if (n > limit) begin
        $display("Timeout with %0d expected bytes not yet sent", exp_q.size());
        abort_run();
      end
    end
  endtask

  task automatic expect_no_tx(int cycles);
    repeat (cycles) begin
      @(posedge mac_clk);
      check_value("mac_tx_dvld", mac_tx_dvld, 1'b0);
    end
  endtask

  // Writes past the FIFO depth and notes when each flag first shows
  task automatic fill_to_overflow(int count);
    int n;
    afull_at = -1;
    ovf_at   = -1;
    for (int i = 0; i < count; i++) begin
      @(posedge mac_clk);
      if (app_afull && afull_at < 0) afull_at = i;
      if (app_overflow && ovf_at < 0) ovf_at = i;
      app_data <= byte_t'(i);
      app_dvld <= 1'b1;
      app_eof  <= (i == count - 1);
    end
    @(posedge mac_clk);
    app_dvld <= 1'b0;
    app_eof  <= 1'b0;
    n = 0;
    while (!app_overflow) begin
      @(posedge mac_clk);
      n++;
      if (n > 20) begin
        $display("Timeout waiting for app_overflow after the FIFO was overfilled");
        abort_run();
      end
    end
    if (ovf_at < 0) ovf_at = count + n;
  endtask

  always @(posedge mac_clk) begin
    if (!app_rst && mac_tx_dvld && mac_tx_ack) begin
      cap_q.push_back('{sop: sop, eop: eop, data: mac_tx_data});
    end
  end

  always @(negedge mac_clk) begin : compare_beats
    tx_beat_t got;
    tx_beat_t want;
    while (cap_q.size() > 0) begin
      got = cap_q.pop_front();
      assert (exp_q.size() > 0) else begin
        $display("Byte %h was sent at %0t but no frame was expected", got.data, $time);
        abort_run();
      end
      want = exp_q.pop_front();
      check_value("mac_tx_data", got.data, want.data);
      check_value("sop", got.sop, want.sop);
      check_value("eop", got.eop, want.eop);
    end
  end

  // A failed bound assertion ends the run at once
  always @(negedge mac_clk) begin
    assert (UUT.chk.err_count == 0) else begin
      $display("A bound assertion on the DUT failed before %0t", $time);
      abort_run();
    end
  end

  initial begin
    mac_clk      = 1'b0;
    app_rst      = 1'b1;
    app_data     = '0;
    app_dvld     = 1'b0;
    app_eof      = 1'b0;
    app_destip   = '0;
    app_destport = '0;
    local_enable = 1'b1;
    local_cfg    = '{mac: 48'h02_11_22_33_44_55, ip: 32'hC0A8_010A, port: 16'd4000,
                     gateway: 8'h01};
    mac_tx_ack   = 1'b0;
    ack_random   = 1'b0;
    frame_num    = 0;
    seed         = 32'h3131;
    // Queued frame lengths and destinations drawn before the clock runs
    for (int i = 0; i < 5; i++) begin
      rand_len[i] = frame_len_t'(($random(seed) & 32'h7F) + 1);
      rand_ip[i]  = (i % 2 == 0) ? {24'hC0A801, byte_t'($random(seed))} : 32'h0A00_0001 + i;
    end
    hold_reset();

    send_frame(1, 32'hC0A8_0137, 16'd5000);
    wait_drained(500);
    send_frame(64, 32'hC0A8_0142, 16'd5001);
    wait_drained(500);
    // Off-subnet goes through the gateway entry
    send_frame(20, 32'h0A01_0203, 16'd53);
    wait_drained(500);

    ack_random <= 1'b1;
    for (int i = 0; i < 5; i++) begin
      send_frame(rand_len[i], rand_ip[i], udp_port_t'(6000 + i));
    end
    wait_drained(5000);

    // Disabled transmitter keeps its queue
    local_enable <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      send_frame(frame_len_t'(10 + 7 * i), 32'hC0A8_0105, 16'd7000);
    end
    expect_no_tx(100);
    local_enable <= 1'b1;
    wait_drained(3000);

    local_enable <= 1'b0;
    fill_to_overflow(2100);
    assert (afull_at >= 0 && afull_at < ovf_at) else begin
      $display("app_afull did not rise before app_overflow (afull %0d, overflow %0d)",
               afull_at, ovf_at);
      abort_run();
    end
    local_enable <= 1'b1;
    expect_no_tx(100);
    hold_reset();
    @(posedge mac_clk);
    check_value("app_overflow", app_overflow, 1'b0);
    check_value("app_afull", app_afull, 1'b0);
    expect_no_tx(20);

    if (UUT.chk.err_count == 0 && exp_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Bound assertions failed or expected bytes were left unsent");
      abort_run();
    end
  end

endmodule

// ==== all.f ====
+incdir+src
src/udp_tx_pkg.sv
src/udp_tx_fifo.sv
src/udp_tx_app_if.sv
src/udp_tx_hdr_calc.sv
src/udp_tx_framer.sv
src/udp_tx_top.sv
verification/udp_tx_checker.sv
verification/udp_tx_tb.sv
